//--- verilog.f
+incdir+dv
logic/union_find_pkg.sv
logic/root_election.sv
logic/boundary_tracker.sv
logic/direct_message_unit.sv
logic/cluster_state.sv
logic/processing_unit.sv
dv/processing_unit_tb.sv

//--- Bender.yml
package:
  name: union_find_processing_unit

sources:
  - logic/union_find_pkg.sv
  - logic/root_election.sv
  - logic/boundary_tracker.sv
  - logic/direct_message_unit.sv
  - logic/cluster_state.sv
  - logic/processing_unit.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/processing_unit_tb.sv

//--- dv/pu_checks.svh
`ifndef PU_CHECKS_SVH
`define PU_CHECKS_SVH

// strobes and roots straight out of reset
reset_strobes_low: assert property (@(posedge clk)
    reset |=> {union_out_valid, direct_out_valid, direct_in_taken, neighbor_increase} == '0)
    else report_mismatch("control strobes", 32'($sampled({union_out_valid,
        direct_out_valid, direct_in_taken, neighbor_increase})), 32'd0);

reset_old_root: assert property (@(posedge clk) reset |=> old_root == unit_address)
    else report_mismatch("old_root", 32'($sampled(old_root)), 32'($sampled(unit_address)));

reset_updated_root: assert property (@(posedge clk) reset |=> updated_root == unit_address)
    else report_mismatch("updated_root", 32'($sampled(updated_root)),
        32'($sampled(unit_address)));

// without a sync stage the cluster identity stays our own address
old_root_kept: assert property (@(posedge clk) disable iff (reset)
    old_root == unit_address)
    else report_mismatch("old_root", 32'($sampled(old_root)), 32'($sampled(unit_address)));

odd_cluster_flag: assert property (@(posedge clk) disable iff (reset)
    is_odd_cluster == model_odd)
    else report_mismatch("is_odd_cluster", 32'($sampled(is_odd_cluster)),
        32'($sampled(model_odd)));

cardinality_flag: assert property (@(posedge clk) disable iff (reset)
    is_odd_cardinality == model_card)
    else report_mismatch("is_odd_cardinality", 32'($sampled(is_odd_cardinality)),
        32'($sampled(model_card)));

root_follows_min: assert property (@(posedge clk) disable iff (reset)
    updated_root == model_root)
    else report_mismatch("updated_root", 32'($sampled(updated_root)),
        32'($sampled(model_root)));

// a union broadcast only when the elected root is smaller
union_valid_on_change: assert property (@(posedge clk) disable iff (reset)
    union_out_valid == (exp_stage == stage_spread_cluster && spread_min < model_root))
    else report_mismatch("union_out_valid", 32'($sampled(union_out_valid)),
        32'($sampled(exp_stage == stage_spread_cluster && spread_min < model_root)));

// each channel pairs the grown neighbor's root, or ours, with the new root
for (genvar n = 0; n < neighbor_count; n++) begin : g_union_out
    union_out_new_root: assert property (@(posedge clk) disable iff (reset)
        union_out_valid |-> union_out[n].updated_root == spread_min)
        else report_mismatch("union_out.updated_root",
            32'($sampled(union_out[n].updated_root)), 32'($sampled(spread_min)));

    union_out_old_root: assert property (@(posedge clk) disable iff (reset)
        union_out_valid |-> union_out[n].old_root ==
            (neighbors[n].is_fully_grown ? neighbors[n].old_root : unit_address))
        else report_mismatch("union_out.old_root", 32'($sampled(union_out[n].old_root)),
            32'($sampled(neighbors[n].is_fully_grown ? neighbors[n].old_root
                                                     : unit_address)));
end

growth_pulse: assert property (@(posedge clk) disable iff (reset)
    neighbor_increase == expected_pulse)
    else report_mismatch("neighbor_increase", 32'($sampled(neighbor_increase)),
        32'($sampled(expected_pulse)));

touching_flag: assert property (@(posedge clk) disable iff (reset)
    is_touching_boundary == model_touch)
    else report_mismatch("is_touching_boundary", 32'($sampled(is_touching_boundary)),
        32'($sampled(model_touch)));

taken_same_cycle: assert property (@(posedge clk) disable iff (reset)
    direct_in_taken == expected_taken)
    else report_mismatch("direct_in_taken", 32'($sampled(direct_in_taken)),
        32'($sampled(expected_taken)));

// back-pressure freezes the outgoing message
held_while_full: assert property (@(posedge clk) disable iff (reset)
    direct_out_valid && direct_out_is_full && exp_stage == stage_spread_cluster
    |=> direct_out_valid && $stable(direct_out))
    else report_failure("direct_out changed or dropped valid while is_full was high");

own_receiver: assert property (@(posedge clk) disable iff (reset)
    check_direct && direct_out_valid |-> direct_out.receiver == expected_receiver)
    else report_mismatch("direct_out.receiver", 32'($sampled(direct_out.receiver)),
        32'($sampled(expected_receiver)));

own_parity: assert property (@(posedge clk) disable iff (reset)
    check_direct && direct_out_valid |-> direct_out.is_odd_cardinality)
    else report_mismatch("direct_out.is_odd_cardinality",
        32'($sampled(direct_out.is_odd_cardinality)), 32'd1);

// fresh after loading and no growth yet, so no boundary news
own_touch: assert property (@(posedge clk) disable iff (reset)
    check_direct && direct_out_valid |-> !direct_out.is_touching_boundary)
    else report_mismatch("direct_out.is_touching_boundary",
        32'($sampled(direct_out.is_touching_boundary)), 32'd0);

`endif

//--- dv/processing_unit_tb.sv
`timescale 1ns/1ns

module processing_unit_tb;
    import union_find_pkg::*;

    logic clk;
    logic reset;
    stage_e stage_in;
    logic init_is_error_syndrome;
    neighbor_link_t [neighbor_count-1:0] neighbors;
    union_msg_t [neighbor_count-1:0] union_in;
    logic [neighbor_count-1:0] union_in_valid;
    union_msg_t [neighbor_count-1:0] union_out;
    logic union_out_valid;
    direct_msg_t [direct_in_count-1:0] direct_in;
    logic [direct_in_count-1:0] direct_in_valid;
    logic [direct_in_count-1:0] direct_in_taken;
    direct_msg_t direct_out;
    logic direct_out_valid;
    logic direct_out_is_full;
    logic neighbor_increase;
    address_t old_root;
    address_t updated_root;
    logic is_odd_cluster;
    logic is_odd_cardinality;
    logic is_touching_boundary;

    // reference model of the unit
    address_t unit_address;
    stage_e exp_stage;
    stage_e exp_prev;
    address_t model_root;
    address_t spread_min;
    logic model_odd;
    logic model_card;
    logic model_touch;
    int model_grown;  // growth steps toward both boundaries
    logic expected_pulse;
    logic [direct_in_count-1:0] expected_taken;
    logic taken_odd;
    logic taken_touch;
    logic check_direct;
    address_t expected_receiver;

    integer seed;
    int error_count;
    int timeout_count;

    processing_unit #(.pos_i(1), .pos_j(0), .pos_k(0)) u_processing_unit (
        .clk, .reset, .stage_in, .init_is_error_syndrome, .neighbors,
        .union_in, .union_in_valid, .union_out, .union_out_valid,
        .direct_in, .direct_in_valid, .direct_in_taken,
        .direct_out, .direct_out_valid, .direct_out_is_full, .neighbor_increase,
        .old_root, .updated_root, .is_odd_cluster, .is_odd_cardinality, .is_touching_boundary
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count++;
        $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // smallest root among the unit's own and the fully grown neighbors
    function automatic address_t grown_min(input address_t base,
                                           input neighbor_link_t [neighbor_count-1:0] links);
        address_t best;
        best = base;
        for (int n = 0; n < neighbor_count; n++) begin
            if (links[n].is_fully_grown && links[n].old_root < best) begin
                best = links[n].old_root;
            end
        end
        return best;
    endfunction

    assign unit_address = '{k: 5'd0, i: 5'd1, j: 5'd0};
    assign spread_min = grown_min(model_root, neighbors);
    assign expected_pulse = exp_stage == stage_grow_boundary
                            && exp_prev != stage_grow_boundary && model_odd;

    always_comb begin
        taken_odd = 1'b0;
        taken_touch = 1'b0;
        for (int n = 0; n < direct_in_count; n++) begin
            expected_taken[n] = exp_stage == stage_spread_cluster && direct_in_valid[n]
                                && direct_in[n].receiver == unit_address;
            taken_odd = taken_odd ^ (expected_taken[n] && direct_in[n].is_odd_cardinality);
            taken_touch = taken_touch || (expected_taken[n] && direct_in[n].is_touching_boundary);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            exp_stage <= stage_idle;
            exp_prev <= stage_idle;
            model_root <= unit_address;
            model_odd <= 1'b0;
            model_card <= 1'b0;
            model_touch <= 1'b0;
            model_grown <= 0;
        end else begin
            exp_stage <= stage_in;  // stage_in lands one cycle later
            exp_prev <= exp_stage;
            case (exp_stage)
                stage_measurement_loading: begin
                    model_root <= unit_address;
                    model_odd <= init_is_error_syndrome;
                    model_card <= init_is_error_syndrome;
                    model_touch <= 1'b0;
                    model_grown <= 0;
                end
                stage_spread_cluster: begin
                    model_root <= spread_min;
                    model_card <= model_card ^ taken_odd;
                    model_touch <= model_touch || model_grown == boundary_cost_z || taken_touch;
                end
                stage_grow_boundary: begin
                    if (expected_pulse && model_grown < boundary_cost_z) begin
                        model_grown <= model_grown + 1;
                    end
                end
                default: ;
            endcase
        end
    end

    `include "pu_checks.svh"

    task automatic run_stage(input stage_e s, input int cycles);
        @(posedge clk);
        stage_in <= s;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic randomize_links();
        neighbor_link_t [neighbor_count-1:0] links;
        for (int n = 0; n < neighbor_count; n++) begin
            links[n].is_fully_grown = 1'($random(seed));
            links[n].old_root = '{k: 5'd0, i: 5'({$random(seed)} % 3),
                                  j: 5'({$random(seed)} % 12)};  // roots near our own
        end
        neighbors <= links;
    endtask

    task automatic load_syndrome(input logic syndrome);
        @(posedge clk);
        stage_in <= stage_measurement_loading;
        init_is_error_syndrome <= syndrome;
        neighbors <= '0;
        direct_out_is_full <= 1'b0;
        @(posedge clk);
    endtask

    task automatic spread_random(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            stage_in <= stage_spread_cluster;
            randomize_links();
            direct_out_is_full <= 1'($random(seed));
        end
    endtask

    task automatic take_direct_in();
        int waited;
        direct_msg_t mine;
        direct_msg_t other;
        mine = '{receiver: unit_address, is_odd_cardinality: 1'b1, is_touching_boundary: 1'b0};
        other = '{receiver: '{k: 5'd0, i: 5'd7, j: 5'd7}, is_odd_cardinality: 1'b1,
                  is_touching_boundary: 1'b0};
        run_stage(stage_spread_cluster, 2);
        @(posedge clk);
        direct_in[0] <= mine;
        direct_in[2] <= other;  // meant for another unit, stays on the channel
        direct_in_valid <= 3'b101;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!direct_in_taken[0] && waited < 20);
        if (!direct_in_taken[0]) begin
            report_timeout("direct input addressed to the unit was never taken");
        end
        @(posedge clk);
        direct_in_valid <= 3'b000;
        run_stage(stage_spread_cluster, 2);
    endtask

    task automatic push_own_message();
        int waited;
        logic sent;
        address_t small_root;
        neighbor_link_t [neighbor_count-1:0] links;
        small_root = '{k: 5'd0, i: 5'd0, j: 5'd3};
        links = '0;
        links[1] = '{is_fully_grown: 1'b1, old_root: small_root};
        @(posedge clk);
        stage_in <= stage_spread_cluster;
        neighbors <= links;
        check_direct <= 1'b1;
        expected_receiver <= small_root;
        waited = 0;
        sent = 1'b0;
        while (!sent && waited < 60) begin
            @(posedge clk);
            // full for the first cycles, then random back-pressure
            direct_out_is_full <= (waited < 4) ? 1'b1 : 1'($random(seed));
            @(negedge clk);
            sent = direct_out_valid && !direct_out_is_full;
            waited++;
        end
        if (!sent) begin
            report_timeout("own direct message never left the unit");
        end
        @(posedge clk);
        direct_out_is_full <= 1'b0;
        run_stage(stage_spread_cluster, 3);
    endtask

    initial begin
        seed = 32'hb8fc_81a9;
        error_count = 0;
        timeout_count = 0;
        reset = 1'b1;
        stage_in = stage_idle;
        init_is_error_syndrome = 1'b0;
        neighbors = '0;
        union_in = '0;
        union_in_valid = '0;
        direct_in = '0;
        direct_in_valid = '0;
        direct_out_is_full = 1'b0;
        check_direct = 1'b0;
        expected_receiver = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        run_stage(stage_idle, 3);
        load_syndrome(1'b1);
        spread_random(16);
        // two growth rounds reach both boundaries
        run_stage(stage_grow_boundary, 2);
        run_stage(stage_spread_cluster, 2);
        run_stage(stage_grow_boundary, 2);
        run_stage(stage_spread_cluster, 2);
        take_direct_in();
        load_syndrome(1'b1);
        push_own_message();
        run_stage(stage_idle, 3);
        $display("value errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- logic/processing_unit.sv
`timescale 1ns/1ns

module processing_unit #(
    parameter int pos_i = 0,
    parameter int pos_j = 0,
    parameter int pos_k = 0
) (
    input  logic clk,
    input  logic reset,
    input  union_find_pkg::stage_e stage_in,
    input  logic init_is_error_syndrome,
    input  union_find_pkg::neighbor_link_t [union_find_pkg::neighbor_count-1:0] neighbors,
    input  union_find_pkg::union_msg_t [union_find_pkg::neighbor_count-1:0] union_in,
    input  logic [union_find_pkg::neighbor_count-1:0] union_in_valid,
    output union_find_pkg::union_msg_t [union_find_pkg::neighbor_count-1:0] union_out,
    output logic union_out_valid,
    input  union_find_pkg::direct_msg_t [union_find_pkg::direct_in_count-1:0] direct_in,
    input  logic [union_find_pkg::direct_in_count-1:0] direct_in_valid,
    output logic [union_find_pkg::direct_in_count-1:0] direct_in_taken,
    output union_find_pkg::direct_msg_t direct_out,
    output logic direct_out_valid,
    input  logic direct_out_is_full,
    output logic neighbor_increase,
    output union_find_pkg::address_t old_root,
    output union_find_pkg::address_t updated_root,
    output logic is_odd_cluster,
    output logic is_odd_cardinality,
    output logic is_touching_boundary
);
    import union_find_pkg::*;

    address_t my_address;
    stage_e stage;
    stage_e stage_prev;
    stage_e stage_delayed;
    address_t new_root;
    logic boundary_reached;
    logic local_odd_toggle;
    logic local_touch;
    logic gathered_odd_cluster;
    logic sync_broadcast;

    assign my_address = '{k: per_dim_width'(pos_k),
                          i: per_dim_width'(pos_i),
                          j: per_dim_width'(pos_j)};

    cluster_state u_cluster_state (
        .clk, .reset, .stage_in, .init_is_error_syndrome, .my_address, .new_root,
        .boundary_reached, .local_odd_toggle, .local_touch, .gathered_odd_cluster,
        .stage, .stage_prev, .stage_delayed, .old_root, .updated_root,
        .is_odd_cluster, .is_odd_cardinality, .is_touching_boundary, .sync_broadcast
    );

    root_election u_root_election (
        .stage, .old_root, .updated_root, .neighbors, .union_in, .union_in_valid,
        .sync_broadcast, .new_root, .gathered_odd_cluster, .union_out, .union_out_valid
    );

    // z boundary on both j edges, up-down boundary on the bottom layer
    boundary_tracker #(
        .has_z(pos_j == 0 || pos_j == code_distance_z - 1),
        .has_ud(pos_k == 0)
    ) u_boundary_tracker (
        .clk, .reset, .stage, .stage_prev, .is_odd_cluster,
        .neighbor_increase, .boundary_reached
    );

    // the controller holds the syndrome level through the decode
    direct_message_unit u_direct_message_unit (
        .clk, .reset, .stage, .stage_delayed, .my_address, .new_root, .updated_root,
        .is_error_syndrome_seen(init_is_error_syndrome),
        .is_touching_boundary,
        .touching_next(boundary_reached),
        .direct_in, .direct_in_valid, .direct_in_taken,
        .direct_out, .direct_out_valid, .direct_out_is_full,
        .local_odd_toggle, .local_touch
    );

endmodule

//--- logic/cluster_state.sv
`timescale 1ns/1ns

module cluster_state (
    input  logic clk,
    input  logic reset,
    input  union_find_pkg::stage_e stage_in,
    input  logic init_is_error_syndrome,
    input  union_find_pkg::address_t my_address,
    input  union_find_pkg::address_t new_root,
    input  logic boundary_reached,
    input  logic local_odd_toggle,
    input  logic local_touch,
    input  logic gathered_odd_cluster,
    output union_find_pkg::stage_e stage,
    output union_find_pkg::stage_e stage_prev,
    output union_find_pkg::stage_e stage_delayed,
    output union_find_pkg::address_t old_root,
    output union_find_pkg::address_t updated_root,
    output logic is_odd_cluster,
    output logic is_odd_cardinality,
    output logic is_touching_boundary,
    output logic sync_broadcast
);
    import union_find_pkg::*;

    logic own_odd_root;
    logic is_sync;
    logic sync_entry;

    // root of an odd cluster that has not met a boundary yet
    assign own_odd_root = my_address == updated_root && is_odd_cardinality
                          && !is_touching_boundary;
    assign is_sync = stage == stage_sync_is_odd_cluster;
    assign sync_entry = is_sync && stage_prev != stage_sync_is_odd_cluster;

    // broadcast only when the flag is new to this unit
    assign sync_broadcast = sync_entry ? own_odd_root
                            : (is_sync && gathered_odd_cluster && !is_odd_cluster);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            stage_prev <= stage_idle;
            stage_delayed <= stage_idle;
        end else begin
            stage <= stage_in;
            stage_delayed <= stage;
            // loading restarts the stage history
            stage_prev <= (stage == stage_measurement_loading) ? stage_idle : stage;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            old_root <= my_address;
            updated_root <= my_address;
            is_odd_cluster <= 1'b0;
            is_odd_cardinality <= 1'b0;
            is_touching_boundary <= 1'b0;
        end else begin
            case (stage)
                stage_measurement_loading: begin
                    old_root <= my_address;
                    updated_root <= my_address;
                    is_odd_cluster <= init_is_error_syndrome;
                    is_odd_cardinality <= init_is_error_syndrome;
                    is_touching_boundary <= 1'b0;
                end
                stage_spread_cluster: begin
                    updated_root <= new_root;
                    is_odd_cardinality <= is_odd_cardinality ^ local_odd_toggle;
                    is_touching_boundary <= is_touching_boundary || boundary_reached
                                            || local_touch;
                end
                stage_sync_is_odd_cluster: begin
                    if (sync_entry) begin
                        is_odd_cluster <= own_odd_root;
                        old_root <= updated_root;  // cluster identity for the next round
                    end else begin
                        is_odd_cluster <= is_odd_cluster || gathered_odd_cluster;
                    end
                end
                default: ;  // idle and grow_boundary leave the cluster alone
            endcase
        end
    end

    // roots only shrink between loadings
    assert property (@(posedge clk) disable iff (reset)
        stage != stage_measurement_loading |=> updated_root <= $past(updated_root));

endmodule

//--- logic/direct_message_unit.sv
`timescale 1ns/1ns

module direct_message_unit (
    input  logic clk,
    input  logic reset,
    input  union_find_pkg::stage_e stage,
    input  union_find_pkg::stage_e stage_delayed,
    input  union_find_pkg::address_t my_address,
    input  union_find_pkg::address_t new_root,
    input  union_find_pkg::address_t updated_root,
    input  logic is_error_syndrome_seen,
    input  logic is_touching_boundary,
    input  logic touching_next,
    input  union_find_pkg::direct_msg_t [union_find_pkg::direct_in_count-1:0] direct_in,
    input  logic [union_find_pkg::direct_in_count-1:0] direct_in_valid,
    output logic [union_find_pkg::direct_in_count-1:0] direct_in_taken,
    output union_find_pkg::direct_msg_t direct_out,
    output logic direct_out_valid,
    input  logic direct_out_is_full,
    output logic local_odd_toggle,
    output logic local_touch
);
    import union_find_pkg::*;

    logic [direct_in_count-1:0] odd_bits;
    logic [direct_in_count-1:0] touch_bits;
    logic is_spread;
    logic root_changed;
    logic touching_updated;
    logic tell_cardinality;
    logic tell_touching;
    logic make_own;
    direct_msg_t stored_msg;
    logic stored_valid;
    logic buffer_valid;
    logic buffer_load;
    logic buffer_sent;

    assign is_spread = stage == stage_spread_cluster;

    genvar n;
    for (n = 0; n < direct_in_count; n++) begin : g_direct_in
        // messages for other units stay on the channel
        assign direct_in_taken[n] = is_spread && direct_in_valid[n]
                                    && direct_in[n].receiver == my_address;
        assign odd_bits[n] = direct_in_taken[n] && direct_in[n].is_odd_cardinality;
        assign touch_bits[n] = direct_in_taken[n] && direct_in[n].is_touching_boundary;
    end

    assign local_odd_toggle = ^odd_bits;
    assign local_touch = |touch_bits;

    // touching_next is boundary contact from our own growth
    assign root_changed = new_root != updated_root;
    assign touching_updated = is_touching_boundary || touching_next || local_touch;
    assign tell_cardinality = root_changed && is_error_syndrome_seen;
    assign tell_touching = (root_changed && touching_updated)
                           || (touching_updated && !is_touching_boundary);

    // a root keeps its own news, nothing to send
    assign make_own = is_spread && (tell_cardinality || tell_touching)
                      && new_root != my_address;

    assign buffer_load = stored_valid && !buffer_valid;
    assign direct_out_valid = buffer_valid && stage_delayed == stage_spread_cluster;
    assign buffer_sent = direct_out_valid && !direct_out_is_full;

    always_ff @(posedge clk) begin
        if (reset || stage == stage_measurement_loading) begin
            stored_valid <= 1'b0;
            buffer_valid <= 1'b0;
        end else begin
            if (make_own) begin
                stored_valid <= 1'b1;  // newer root replaces an unsent one
            end else if (buffer_load) begin
                stored_valid <= 1'b0;
            end
            if (buffer_load) begin
                buffer_valid <= 1'b1;
            end else if (buffer_sent) begin
                buffer_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (make_own) begin
            stored_msg <= '{receiver: new_root,
                            is_odd_cardinality: tell_cardinality,
                            is_touching_boundary: tell_touching};
        end
        if (buffer_load) begin
            direct_out <= stored_msg;
        end
    end

    // blocked message waits unchanged for the channel
    assert property (@(posedge clk) disable iff (reset)
        direct_out_valid && direct_out_is_full && stage != stage_measurement_loading
        |=> $stable(direct_out) && buffer_valid);

endmodule

//--- logic/boundary_tracker.sv
`timescale 1ns/1ns

module boundary_tracker #(
    parameter bit has_z = 1'b0,
    parameter bit has_ud = 1'b0
) (
    input  logic clk,
    input  logic reset,
    input  union_find_pkg::stage_e stage,
    input  union_find_pkg::stage_e stage_prev,
    input  logic is_odd_cluster,
    output logic neighbor_increase,
    output logic boundary_reached
);
    import union_find_pkg::*;

    logic [1:0] has_boundary;  // bit 0 z, bit 1 up-down
    logic [boundary_width-1:0] cost [2];
    logic [boundary_width-1:0] grown [2];
    logic [1:0] reached;

    assign has_boundary = {has_ud, has_z};
    assign cost[0] = boundary_width'(boundary_cost_z);
    assign cost[1] = boundary_width'(boundary_cost_ud);

    // one pulse per entry into grow_boundary, odd clusters only
    assign neighbor_increase = is_odd_cluster && stage == stage_grow_boundary
                               && stage_prev != stage_grow_boundary;

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (reset || stage == stage_measurement_loading) begin
                grown[b] <= '0;
            end else if (neighbor_increase && has_boundary[b] && grown[b] < cost[b]) begin
                grown[b] <= grown[b] + 1'b1;  // saturates at the cost
            end
        end
    end

    genvar b;
    for (b = 0; b < 2; b++) begin : g_reached
        assign reached[b] = has_boundary[b] && grown[b] == cost[b];
    end

    assign boundary_reached = |reached;

endmodule

//--- logic/root_election.sv
`timescale 1ns/1ns

module root_election (
    input  union_find_pkg::stage_e stage,
    input  union_find_pkg::address_t old_root,
    input  union_find_pkg::address_t updated_root,
    input  union_find_pkg::neighbor_link_t [union_find_pkg::neighbor_count-1:0] neighbors,
    input  union_find_pkg::union_msg_t [union_find_pkg::neighbor_count-1:0] union_in,
    input  logic [union_find_pkg::neighbor_count-1:0] union_in_valid,
    input  logic sync_broadcast,
    output union_find_pkg::address_t new_root,
    output logic gathered_odd_cluster,
    output union_find_pkg::union_msg_t [union_find_pkg::neighbor_count-1:0] union_out,
    output logic union_out_valid
);
    import union_find_pkg::*;

    logic [neighbor_count-1:0] accepted;
    // heap layout, leaves first, node neighbor_count + m takes children 2m and 2m + 1
    logic [address_width-1:0] node [2*neighbor_count-1];
    logic [address_width-1:0] tree_min;

    genvar n;
    for (n = 0; n < neighbor_count; n++) begin : g_channel
        // only messages from our own old cluster count
        assign accepted[n] = union_in_valid[n] && (union_in[n].old_root == old_root);

        // a union message wins over the link on the same channel
        assign node[n] = accepted[n] ? union_in[n].updated_root :
                         neighbors[n].is_fully_grown ? neighbors[n].old_root :
                         updated_root;

        always_comb begin
            if (sync_broadcast) begin
                union_out[n] = '{old_root: updated_root, updated_root: updated_root};
            end else begin
                union_out[n].old_root = neighbors[n].is_fully_grown ?
                                        neighbors[n].old_root : old_root;
                union_out[n].updated_root = new_root;
            end
        end
    end

    for (n = 0; n < neighbor_count - 1; n++) begin : g_min_tree
        assign node[neighbor_count+n] = (node[2*n] < node[2*n+1]) ? node[2*n] : node[2*n+1];
    end

    assign tree_min = node[2*neighbor_count-2];  // settles within the cycle
    // larger offers on every channel leave our own root in place
    assign new_root = (tree_min < updated_root) ? tree_min : updated_root;
    assign gathered_odd_cluster = |accepted;
    assign union_out_valid = (stage == stage_spread_cluster && new_root != updated_root)
                             || sync_broadcast;

    // elected roots never climb above the root the round started from
    assert final ($isunknown(old_root) || new_root <= old_root);

endmodule

//--- logic/union_find_pkg.sv
package union_find_pkg;

    localparam int per_dim_width = 5;
    localparam int address_width = 3 * per_dim_width;  // k, i, j
    localparam int neighbor_count = 4;  // also the union channel count
    localparam int direct_in_count = 3;
    localparam int boundary_width = 2;
    localparam int code_distance_z = 12;
    localparam int boundary_cost_z = 2;
    localparam int boundary_cost_ud = 2;

    typedef enum logic [2:0] {
        stage_idle = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_spread_cluster = 3'd2,
        stage_grow_boundary = 3'd3,
        stage_sync_is_odd_cluster = 3'd4
    } stage_e;

    // k is the most significant field, so roots order by layer first
    typedef struct packed {
        logic [per_dim_width-1:0] k;
        logic [per_dim_width-1:0] i;
        logic [per_dim_width-1:0] j;
    } address_t;

    typedef struct packed {
        address_t old_root;
        address_t updated_root;
    } union_msg_t;

    typedef struct packed {
        address_t receiver;
        logic is_odd_cardinality;
        logic is_touching_boundary;
    } direct_msg_t;

    typedef struct packed {
        logic is_fully_grown;
        address_t old_root;
    } neighbor_link_t;

endpackage
